/* dmem_if.sv */
// Request bus from the memory stage to the byte lanes and the collector

`timescale 1ns/1ps
`default_nettype none

interface dmem_if
    import mem_pkg::*;
();

    // One-cycle request strobe, always accepted
    logic                 req_valid;
    // High for a store, low for a load
    logic                 req_write;
    // Byte address
    word_t                req_addr;
    // Per-lane write strobes
    logic [NUM_LANES-1:0] req_strb;
    // Store data already shifted into its lanes
    word_t                req_wdata;

    // Memory stage side
    modport req (
        output req_valid, req_write, req_addr, req_strb, req_wdata
    );

    // Lanes and collector side
    modport mem (
        input req_valid, req_write, req_addr, req_strb, req_wdata
    );

endinterface

`default_nettype wire

/* dmem_lane.sv */
// One byte-wide synchronous data memory bank

`timescale 1ns/1ps
`default_nettype none

module dmem_lane
    import mem_pkg::*;
#(
    // Byte position of this bank within the word
    parameter int unsigned LANE = 0
) (
    input  logic       clk_i,
    dmem_if.mem        dmem,
    // Already gated by valid, write, strobe and range in the collector
    input  logic       lane_we_i,
    output logic [7:0] rdata_o
);

    logic [7:0]         mem_q [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [7:0]         rdata_q;

    // Out-of-range addresses wrap here, the collector masks them
    assign word_idx = dmem.req_addr[DMEM_AW+1:2];

    always_ff @(posedge clk_i) begin
        if (lane_we_i) begin
            mem_q[word_idx] <= dmem.req_wdata[LANE*8 +: 8];
        end
        // Read on every request, old data on a write
        if (dmem.req_valid) begin
            rdata_q <= mem_q[word_idx];
        end
    end

    assign rdata_o = rdata_q;

    // The enable from the collector must match this lane's own strobe
    a_we_matches_strb: assert property (
        @(posedge clk_i)
        lane_we_i |-> dmem.req_valid && dmem.req_write && dmem.req_strb[LANE]
    ) else $error("lane write without a strobed write request");

endmodule

`default_nettype wire

/* dmem_rsp.sv */
// Data memory response collector
// Range decode, per-lane write enables, word merge and access fault

`timescale 1ns/1ps
`default_nettype none

module dmem_rsp
    import mem_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    dmem_if.mem                       dmem,
    input  logic [NUM_LANES-1:0][7:0] lane_rdata_i,
    output logic [NUM_LANES-1:0]      we_o,
    output logic                      rsp_valid_o,
    output logic                      rsp_error_o,
    output word_t                     rsp_data_o
);

    logic       in_range;
    logic       valid_q;
    logic       in_range_q;
    lane_word_u rsp_word;

    // Memory covers bytes 0 to 1023
    assign in_range = dmem.req_addr < word_t'(DMEM_WORDS * NUM_LANES);

    // Range is decoded here only, lanes just follow their enable
    assign we_o = dmem.req_strb & {NUM_LANES{dmem.req_valid & dmem.req_write & in_range}};

    // ==============================
    // Response cycle
    // ==============================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= 1'b0;
            in_range_q <= 1'b0;
        end else begin
            valid_q    <= dmem.req_valid;
            in_range_q <= in_range;
        end
    end

    // Lane 0 is the least significant byte
    assign rsp_word.bytes = lane_rdata_i;

    assign rsp_valid_o = valid_q;
    assign rsp_error_o = valid_q & ~in_range_q;
    // Faulting reads return zero
    assign rsp_data_o  = in_range_q ? rsp_word : '0;

    // Every request is answered in the next cycle and nothing else is
    a_rsp_follows_req: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_o == $past(dmem.req_valid)
    ) else $error("response valid not one cycle after request");

endmodule

`default_nettype wire

/* mem_pkg.sv */
// Shared sizes, funct3 access codes and memory exception causes
// Lane-word union and the memory exception record

`default_nettype none

package mem_pkg;

    // ==============================
    // Sizes
    // ==============================

    // Data and address width
    localparam int unsigned XLEN       = 32;
    // Byte lanes per word
    localparam int unsigned NUM_LANES  = 4;
    // Depth of each byte lane, 1 KiB in total
    localparam int unsigned DMEM_WORDS = 256;
    // Word index width
    localparam int unsigned DMEM_AW    = $clog2(DMEM_WORDS);

    typedef logic [XLEN-1:0] word_t;

    // ==============================
    // Load and store access codes
    // ==============================

    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

    // Exception causes raised by the memory stage
    localparam logic [3:0] CAUSE_LOAD_MISALIGNED  = 4'd4;
    localparam logic [3:0] CAUSE_LOAD_FAULT       = 4'd5;
    localparam logic [3:0] CAUSE_STORE_MISALIGNED = 4'd6;
    localparam logic [3:0] CAUSE_STORE_FAULT      = 4'd7;

    // ==============================
    // Types
    // ==============================

    // One word seen as four bytes or as two halfwords
    // Index 0 is the least significant byte or halfword
    typedef union packed {
        logic [NUM_LANES-1:0][7:0] bytes;
        logic [1:0][15:0]          halves;
    } lane_word_u;

    // Memory exception record, tval holds the offending address
    typedef struct packed {
        logic       valid;
        logic [3:0] cause;
        word_t      pc;
        word_t      tval;
    } mem_exc_t;

endpackage

`default_nettype wire

/* mem_stage.sv */
// Memory stage of the RV32 pipeline
// Store alignment, misalignment check, request control, load extraction
// Exception record and the MEM/WB register

`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import mem_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       stall_w_i,
    input  logic       flush_m_i,

    // EX/MEM entry
    input  word_t      ex_alu_result_i,
    input  word_t      ex_store_data_i,
    input  word_t      ex_pc_i,
    input  logic [2:0] ex_funct3_i,
    input  logic       ex_mem_read_i,
    input  logic       ex_mem_write_i,
    input  logic       ex_reg_write_i,
    input  logic [4:0] ex_rd_addr_i,

    // Data memory request and response
    dmem_if.req        dmem,
    input  logic       rsp_valid_i,
    input  logic       rsp_error_i,
    input  word_t      rsp_data_i,

    // Execute side must hold its entry while this is high
    output logic       busy_o,

    // MEM/WB outputs
    output word_t      wb_data_o,
    output logic [4:0] wb_rd_addr_o,
    output logic       wb_reg_write_o,
    output mem_exc_t   exc_o
);

    logic [1:0]           addr_lsb;
    logic                 misaligned;
    logic                 load_misal;
    logic                 store_misal;
    logic                 need_mem;
    logic                 mem_done;
    logic                 wb_fire;
    logic [NUM_LANES-1:0] store_strb;

    // Request in flight, response due this cycle
    logic                 waiting_q;
    // Response captured during a stall, not yet latched
    logic                 have_rsp_q;
    word_t                rsp_data_q;
    logic                 rsp_err_q;

    lane_word_u           rd_word;
    logic                 rd_err;
    word_t                load_data;
    word_t                wb_data_d;
    mem_exc_t             exc_d;

    // MEM/WB register
    word_t                wb_data_q;
    logic [4:0]           wb_rd_q;
    logic                 wb_we_q;
    logic                 exc_valid_q;
    logic [3:0]           exc_cause_q;
    word_t                exc_pc_q;
    word_t                exc_tval_q;

    assign addr_lsb = ex_alu_result_i[1:0];

    // ==============================
    // Alignment and store lanes
    // ==============================

    // Halfwords need an even address, words a multiple of four
    always_comb begin
        case (ex_funct3_i)
            F3_H, F3_HU: misaligned = addr_lsb[0];
            F3_W:        misaligned = |addr_lsb;
            default:     misaligned = 1'b0;
        endcase
    end

    assign load_misal  = ex_mem_read_i & misaligned;
    assign store_misal = ex_mem_write_i & misaligned;

    // Misaligned entries never reach memory
    assign need_mem = (ex_mem_read_i | ex_mem_write_i) & ~misaligned;

    // Strobes follow the access size, shifted to the addressed lane
    always_comb begin
        case (ex_funct3_i)
            F3_B:    store_strb = 4'b0001 << addr_lsb;
            F3_H:    store_strb = 4'b0011 << addr_lsb;
            F3_W:    store_strb = 4'b1111;
            default: store_strb = 4'b0000;
        endcase
    end

    // ==============================
    // Request control
    // ==============================

    // One request per entry, even if the entry is held for several cycles
    assign dmem.req_valid = need_mem & ~waiting_q & ~have_rsp_q;
    assign dmem.req_write = ex_mem_write_i;
    assign dmem.req_addr  = ex_alu_result_i;
    assign dmem.req_strb  = store_strb;
    assign dmem.req_wdata = ex_store_data_i << {addr_lsb, 3'b000};

    // Response either arriving now or parked from a stalled cycle
    assign mem_done = rsp_valid_i | have_rsp_q;

    // Memory entries stay busy until MEM/WB has taken them
    assign busy_o = need_mem & ~(mem_done & ~stall_w_i);

    // MEM/WB takes a real entry
    assign wb_fire = ~stall_w_i & ~flush_m_i & (~need_mem | mem_done);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            waiting_q  <= 1'b0;
            have_rsp_q <= 1'b0;
        end else begin
            // The memory always answers one cycle later
            waiting_q <= dmem.req_valid;
            if (rsp_valid_i && stall_w_i) begin
                have_rsp_q <= 1'b1;
            end else if (!stall_w_i) begin
                have_rsp_q <= 1'b0;
            end
        end
    end

    // Parked response payload
    always_ff @(posedge clk_i) begin
        if (rsp_valid_i) begin
            rsp_data_q <= rsp_data_i;
            rsp_err_q  <= rsp_error_i;
        end
    end

    // ==============================
    // Load extraction
    // ==============================

    assign rd_word = have_rsp_q ? rsp_data_q : rsp_data_i;
    assign rd_err  = have_rsp_q ? rsp_err_q : rsp_error_i;

    // Byte picked by both address bits, halfword by bit 1
    always_comb begin
        case (ex_funct3_i)
            F3_B:    load_data = {{24{rd_word.bytes[addr_lsb][7]}}, rd_word.bytes[addr_lsb]};
            F3_H:    load_data = {{16{rd_word.halves[addr_lsb[1]][15]}},
                                  rd_word.halves[addr_lsb[1]]};
            F3_BU:   load_data = {24'b0, rd_word.bytes[addr_lsb]};
            F3_HU:   load_data = {16'b0, rd_word.halves[addr_lsb[1]]};
            default: load_data = rd_word;
        endcase
    end

    assign wb_data_d = ex_mem_read_i ? load_data : ex_alu_result_i;

    // Misalignment wins over an access fault
    always_comb begin
        exc_d = '0;
        if (load_misal) begin
            exc_d.valid = 1'b1;
            exc_d.cause = CAUSE_LOAD_MISALIGNED;
        end else if (store_misal) begin
            exc_d.valid = 1'b1;
            exc_d.cause = CAUSE_STORE_MISALIGNED;
        end else if (need_mem && rd_err) begin
            exc_d.valid = 1'b1;
            exc_d.cause = ex_mem_write_i ? CAUSE_STORE_FAULT : CAUSE_LOAD_FAULT;
        end
        if (exc_d.valid) begin
            exc_d.pc   = ex_pc_i;
            exc_d.tval = ex_alu_result_i;
        end
    end

    // ==============================
    // MEM/WB register
    // ==============================

    // Flush and the wait cycle of a memory entry both load a bubble
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wb_we_q     <= 1'b0;
            exc_valid_q <= 1'b0;
        end else if (!stall_w_i) begin
            wb_we_q     <= wb_fire & ex_reg_write_i;
            exc_valid_q <= wb_fire & exc_d.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_fire) begin
            wb_data_q   <= wb_data_d;
            wb_rd_q     <= ex_rd_addr_i;
            exc_cause_q <= exc_d.cause;
            exc_pc_q    <= exc_d.pc;
            exc_tval_q  <= exc_d.tval;
        end
    end

    assign wb_data_o      = wb_data_q;
    assign wb_rd_addr_o   = wb_rd_q;
    assign wb_reg_write_o = wb_we_q;
    assign exc_o          = '{valid: exc_valid_q, cause: exc_cause_q,
                              pc: exc_pc_q, tval: exc_tval_q};

    // A request is answered in the next cycle, with no new request beside it
    a_one_req_per_wait: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        dmem.req_valid |=> rsp_valid_i && !dmem.req_valid
    ) else $error("request not answered, or strobed while a response was owed");

    // Misaligned entries neither reach memory nor stall the pipeline
    a_no_misaligned_req: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (load_misal || store_misal) |-> !dmem.req_valid && !busy_o
    ) else $error("request or busy raised for a misaligned entry");

endmodule

`default_nettype wire

/* mem_subsys_top.sv */
// Memory stage and data memory subsystem top level
// Stage, four byte lanes and the response collector

`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
    import mem_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       stall_w_i,
    input  logic       flush_m_i,
    input  word_t      ex_alu_result_i,
    input  word_t      ex_store_data_i,
    input  word_t      ex_pc_i,
    input  logic [2:0] ex_funct3_i,
    input  logic       ex_mem_read_i,
    input  logic       ex_mem_write_i,
    input  logic       ex_reg_write_i,
    input  logic [4:0] ex_rd_addr_i,
    output logic       busy_o,
    output word_t      wb_data_o,
    output logic [4:0] wb_rd_addr_o,
    output logic       wb_reg_write_o,
    output logic       exc_valid_o,
    output logic [3:0] exc_cause_o,
    output word_t      exc_pc_o,
    output word_t      exc_tval_o
);

    logic [NUM_LANES-1:0][7:0] lane_rdata;
    logic [NUM_LANES-1:0]      lane_we;
    logic                      rsp_valid;
    logic                      rsp_error;
    word_t                     rsp_data;
    mem_exc_t                  exc;

    dmem_if dmem_bus ();

    mem_stage u_stage (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .stall_w_i       (stall_w_i),
        .flush_m_i       (flush_m_i),
        .ex_alu_result_i (ex_alu_result_i),
        .ex_store_data_i (ex_store_data_i),
        .ex_pc_i         (ex_pc_i),
        .ex_funct3_i     (ex_funct3_i),
        .ex_mem_read_i   (ex_mem_read_i),
        .ex_mem_write_i  (ex_mem_write_i),
        .ex_reg_write_i  (ex_reg_write_i),
        .ex_rd_addr_i    (ex_rd_addr_i),
        .dmem            (dmem_bus),
        .rsp_valid_i     (rsp_valid),
        .rsp_error_i     (rsp_error),
        .rsp_data_i      (rsp_data),
        .busy_o          (busy_o),
        .wb_data_o       (wb_data_o),
        .wb_rd_addr_o    (wb_rd_addr_o),
        .wb_reg_write_o  (wb_reg_write_o),
        .exc_o           (exc)
    );

    // One bank per byte lane
    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        dmem_lane #(
            .LANE (g)
        ) u_lane (
            .clk_i     (clk_i),
            .dmem      (dmem_bus),
            .lane_we_i (lane_we[g]),
            .rdata_o   (lane_rdata[g])
        );
    end

    dmem_rsp u_rsp (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .dmem         (dmem_bus),
        .lane_rdata_i (lane_rdata),
        .we_o         (lane_we),
        .rsp_valid_o  (rsp_valid),
        .rsp_error_o  (rsp_error),
        .rsp_data_o   (rsp_data)
    );

    // Exception record flattened for the ports
    assign exc_valid_o = exc.valid;
    assign exc_cause_o = exc.cause;
    assign exc_pc_o    = exc.pc;
    assign exc_tval_o  = exc.tval;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_mem_subsys -o sim_tb

# The simulator exits nonzero on failure, the log decides the result
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

/* tb_mem_subsys.sv */
// Testbench for the memory stage and data memory subsystem
// LFSR stimulus, byte-array reference memory, concurrent checks, timeout

`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int MAX_CYCLES = 2000;
    localparam int POOL_WORDS = 32;

    logic       clk_i;
    logic       rst_ni;
    logic       stall_w_i;
    logic       flush_m_i;
    word_t      ex_alu_result_i;
    word_t      ex_store_data_i;
    word_t      ex_pc_i;
    logic [2:0] ex_funct3_i;
    logic       ex_mem_read_i;
    logic       ex_mem_write_i;
    logic       ex_reg_write_i;
    logic [4:0] ex_rd_addr_i;
    logic       busy_o;
    word_t      wb_data_o;
    logic [4:0] wb_rd_addr_o;
    logic       wb_reg_write_o;
    logic       exc_valid_o;
    logic [3:0] exc_cause_o;
    word_t      exc_pc_o;
    word_t      exc_tval_o;

    // Expected MEM/WB state, checked at the falling edge while chk is high
    logic       chk = 1'b0;
    logic       chk_data;
    logic       chk_busy;
    word_t      exp_data;
    logic [4:0] exp_rd;
    logic       exp_we;
    logic       exp_exc;
    logic [3:0] exp_cause;
    word_t      exp_pc;
    word_t      exp_tval;
    int         exp_busy;
    int         exp_reqs;
    int         busy_seen;
    int         req_seen;

    int         cycle_cnt = 0;
    int         busy_cnt = 0;
    int         req_cnt = 0;
    logic       stall_q = 1'b0;
    word_t      prev_data;
    logic       prev_we;
    logic       prev_exc;
    logic [31:0] lfsr;
    logic [7:0]  ref_mem [1024];

    mem_subsys_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic fail_now();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic mismatch(input string name, input word_t expv, input word_t actv);
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expv, actv);
        fail_now();
    endtask

    // Busy and request strobes counted per edge, plus stall hold snapshot
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (busy_o) busy_cnt <= busy_cnt + 1;
        if (DUT.dmem_bus.req_valid) req_cnt <= req_cnt + 1;
        stall_q   <= stall_w_i;
        prev_data <= wb_data_o;
        prev_we   <= wb_reg_write_o;
        prev_exc  <= exc_valid_o;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
            fail_now();
        end
    end

    // ==============================
    // Checks
    // ==============================

    a_data: assert property (@(negedge clk_i) chk && chk_data |-> wb_data_o === exp_data)
        else mismatch("wb_data_o", exp_data, wb_data_o);
    a_rd: assert property (@(negedge clk_i) chk && chk_data |-> wb_rd_addr_o === exp_rd)
        else mismatch("wb_rd_addr_o", word_t'(exp_rd), word_t'(wb_rd_addr_o));
    a_we: assert property (@(negedge clk_i) chk |-> wb_reg_write_o === exp_we)
        else mismatch("wb_reg_write_o", word_t'(exp_we), word_t'(wb_reg_write_o));
    a_exc: assert property (@(negedge clk_i) chk |-> exc_valid_o === exp_exc)
        else mismatch("exc_valid_o", word_t'(exp_exc), word_t'(exc_valid_o));
    a_cause: assert property (@(negedge clk_i) chk && exp_exc |-> exc_cause_o === exp_cause)
        else mismatch("exc_cause_o", word_t'(exp_cause), word_t'(exc_cause_o));
    a_tval: assert property (@(negedge clk_i) chk && exp_exc |-> exc_tval_o === exp_tval)
        else mismatch("exc_tval_o", exp_tval, exc_tval_o);
    a_pc: assert property (@(negedge clk_i) chk && exp_exc |-> exc_pc_o === exp_pc)
        else mismatch("exc_pc_o", exp_pc, exc_pc_o);
    a_busy: assert property (@(negedge clk_i) chk && chk_busy |-> busy_seen == exp_busy)
        else mismatch("busy_o cycles", word_t'(exp_busy), word_t'(busy_seen));
    a_reqs: assert property (@(negedge clk_i) chk |-> req_seen == exp_reqs)
        else mismatch("req_valid count", word_t'(exp_reqs), word_t'(req_seen));

    // MEM/WB must not move across an edge taken with stall high
    a_hold_data: assert property (@(negedge clk_i) disable iff (!rst_ni)
        stall_q |-> wb_data_o === prev_data)
        else mismatch("wb_data_o", prev_data, wb_data_o);
    a_hold_we: assert property (@(negedge clk_i) disable iff (!rst_ni)
        stall_q |-> wb_reg_write_o === prev_we)
        else mismatch("wb_reg_write_o", word_t'(prev_we), word_t'(wb_reg_write_o));
    a_hold_exc: assert property (@(negedge clk_i) disable iff (!rst_ni)
        stall_q |-> exc_valid_o === prev_exc)
        else mismatch("exc_valid_o", word_t'(prev_exc), word_t'(exc_valid_o));

    // ==============================
    // Reference model and stimulus
    // ==============================

    // Galois LFSR, one step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA3000000) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic word_t ref_load(input word_t a, input logic [2:0] f3);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = ref_mem[a[9:0]];
        b1 = ref_mem[a[9:0] + 10'd1];
        case (f3)
            F3_B:    return {{24{b0[7]}}, b0};
            F3_BU:   return {24'b0, b0};
            F3_H:    return {{16{b1[7]}}, b1, b0};
            F3_HU:   return {16'b0, b1, b0};
            default: return {ref_mem[a[9:0] + 10'd3], ref_mem[a[9:0] + 10'd2], b1, b0};
        endcase
    endfunction

    // Apply one entry, hold it while busy, then check the latched result
    task automatic run_entry(input word_t alu, input word_t sd, input logic [2:0] f3,
                             input logic rd_en, input logic wr_en, input logic rw,
                             input int stall_n, input logic fl);
        logic mis;
        logic mem;
        mis = (f3 == F3_H || f3 == F3_HU) ? alu[0] : (f3 == F3_W ? |alu[1:0] : 1'b0);
        mem = (rd_en || wr_en) && !mis;
        exp_exc   = !fl && (rd_en || wr_en) && (mis || alu >= 32'd1024);
        exp_cause = mis ? (wr_en ? CAUSE_STORE_MISALIGNED : CAUSE_LOAD_MISALIGNED)
                        : (wr_en ? CAUSE_STORE_FAULT : CAUSE_LOAD_FAULT);
        exp_tval  = alu;
        exp_pc    = rand_bits(30) << 2;
        exp_rd    = 5'(rand_bits(5));
        exp_we    = !fl && rw;
        exp_data  = rd_en ? ref_load(alu, f3) : alu;
        chk_data  = !fl && !exp_exc;
        chk_busy  = (stall_n == 0);
        exp_busy  = mem ? 1 : 0;
        exp_reqs  = mem ? 1 : 0;
        if (wr_en && mem && alu < 32'd1024) begin
            for (int i = 0; i < (f3 == F3_B ? 1 : (f3 == F3_H ? 2 : 4)); i++) begin
                ref_mem[alu[9:0] + 10'(i)] = sd[8*i +: 8];
            end
        end
        ex_alu_result_i = alu;
        ex_store_data_i = sd;
        ex_pc_i         = exp_pc;
        ex_funct3_i     = f3;
        ex_mem_read_i   = rd_en;
        ex_mem_write_i  = wr_en;
        ex_reg_write_i  = rw;
        ex_rd_addr_i    = exp_rd;
        stall_w_i       = (stall_n > 0);
        flush_m_i       = fl;
        busy_seen       = busy_cnt;
        req_seen        = req_cnt;
        repeat (stall_n) @(posedge clk_i);
        if (stall_n > 0) begin
            #5;
            stall_w_i = 1'b0;
        end
        #40;
        while (busy_o) begin
            @(posedge clk_i);
            #45;
        end
        @(posedge clk_i);
        #5;
        busy_seen      = busy_cnt - busy_seen;
        req_seen       = req_cnt - req_seen;
        flush_m_i      = 1'b0;
        ex_mem_read_i  = 1'b0;
        ex_mem_write_i = 1'b0;
        ex_reg_write_i = 1'b0;
        chk = 1'b1;
        @(negedge clk_i);
        #1;
        chk = 1'b0;
        @(posedge clk_i);
        #5;
    endtask

    function automatic word_t pool_addr();
        return rand_bits(5) << 2;
    endfunction

    initial begin
        logic [2:0] f3_list [5];
        logic [2:0] f3;
        word_t      a;
        f3_list = '{F3_B, F3_H, F3_W, F3_BU, F3_HU};
        lfsr = 32'hcc551a61;
        for (int i = 0; i < 1024; i++) ref_mem[i] = 8'h00;
        rst_ni = 1'b0;
        stall_w_i = 1'b0;
        flush_m_i = 1'b0;
        ex_alu_result_i = '0;
        ex_store_data_i = '0;
        ex_pc_i = '0;
        ex_funct3_i = F3_W;
        ex_mem_read_i = 1'b0;
        ex_mem_write_i = 1'b0;
        ex_reg_write_i = 1'b0;
        ex_rd_addr_i = '0;
        repeat (2) @(posedge clk_i);
        #5;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #5;
        // Word pool that later loads read from
        for (int i = 0; i < POOL_WORDS; i++) run_entry(i * 4, rand_bits(32), F3_W, 0, 1, 0, 0, 0);
        for (int i = 0; i < 10; i++) run_entry(rand_bits(32), rand_bits(32), F3_W, 0, 0, 1, 0, 0);
        for (int i = 0; i < 40; i++) begin
            a = pool_addr();
            run_entry(a, rand_bits(32), F3_W, 0, 1, 0, 0, 0);
            run_entry(a, 0, F3_W, 1, 0, 1, 0, 0);
        end
        // Sub-word stores and loads at every legal lane offset
        for (int i = 0; i < 40; i++) begin
            f3 = rand_bits(1) ? F3_H : F3_B;
            a = pool_addr();
            run_entry(a + (f3 == F3_B ? rand_bits(2) : (rand_bits(1) << 1)),
                      rand_bits(32), f3, 0, 1, 0, 0, 0);
            f3 = f3_list[rand_bits(3) % 5];
            run_entry(a + (f3 == F3_W ? 0 : (f3 == F3_B || f3 == F3_BU) ? rand_bits(2)
                      : (rand_bits(1) << 1)), 0, f3, 1, 0, 1, 0, 0);
        end
        for (int i = 0; i < 8; i++) begin
            a = pool_addr();
            f3 = i[1] ? F3_W : F3_H;
            run_entry(a + (f3 == F3_H ? 32'd1 : 32'd2 + i[0]), rand_bits(32), f3,
                      !i[0], i[0], 1, 0, 0);
            run_entry(a, 0, F3_W, 1, 0, 1, 0, 0);
        end
        // Out-of-range accesses alias the pool in the lanes
        for (int i = 0; i < 4; i++) begin
            a = pool_addr();
            run_entry(a + 32'd1024, rand_bits(32), F3_W, 0, 1, 0, 0, 0);
            run_entry(a + 32'd1024 * (i + 1), 0, F3_W, 1, 0, 1, 0, 0);
            run_entry(a, 0, F3_W, 1, 0, 1, 0, 0);
        end
        // Stalled entries, a faulting load among them
        for (int i = 0; i < 3; i++) begin
            a = pool_addr();
            run_entry(a, rand_bits(32), F3_W, 0, 1, 0, 3, 0);
            run_entry(a, 0, F3_W, 1, 0, 1, 2 + i, 0);
            run_entry(a + 32'd1024, 0, F3_W, 1, 0, 1, 2, 0);
        end
        // Flushed misaligned loads leave neither a write nor an exception
        for (int i = 0; i < 3; i++) run_entry(rand_bits(32) | 32'd1, 0, F3_W, 1, 0, 1, 0, 1);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
mem_pkg.sv
dmem_if.sv
mem_stage.sv
dmem_lane.sv
dmem_rsp.sv
mem_subsys_top.sv
tb_mem_subsys.sv
